// File: logic/bitCount_cfg.svh
// bit-count unit sizing macros shared by packages, interface and RTL
`ifndef BIT_COUNT_CFG_SVH
`define BIT_COUNT_CFG_SVH

// full operand handled by the unit
`define BC_OPERAND_WIDTH 64

// one lane counts one byte of the aligned word
`define BC_LANE_WIDTH 8

// lanes needed to cover the operand
`define BC_NUM_LANES 8

// final count holds 0 to 64
`define BC_COUNT_WIDTH 7

// lane count holds 0 to 8
`define BC_LANE_COUNT_WIDTH 4

`endif

// File: logic/countOpPkg.sv
// operation and operand width encodings for the bit-count unit
`default_nettype none

package countOpPkg;

	// what is counted, and from which end
	typedef enum logic [1:0] {
		opLeadZero  = 2'd0,
		opLeadOne   = 2'd1,
		opTrailZero = 2'd2,
		opTrailOne  = 2'd3
	} countOpT;

	// low bits of the operand that take part in the count
	typedef enum logic [1:0] {
		width8  = 2'd0,
		width16 = 2'd1,
		width32 = 2'd2,
		width64 = 2'd3
	} opWidthT;

endpackage

`default_nettype wire

// File: logic/countDataPkg.sv
// data vector types for operand, lane slice and count values
`default_nettype none

`include "bitCount_cfg.svh"

package countDataPkg;

	// raw operand and the aligned word derived from it
	typedef logic [`BC_OPERAND_WIDTH-1:0] operandT;

	// one lane's byte of the aligned word
	typedef logic [`BC_LANE_WIDTH-1:0] laneDataT;

	// leading-zero count of one lane, 0 to 8
	typedef logic [`BC_LANE_COUNT_WIDTH-1:0] laneCountT;

	// final count, 0 to 64
	typedef logic [`BC_COUNT_WIDTH-1:0] bitCountT;

endpackage

`default_nettype wire

// File: logic/countPipeIf.sv
// pipeline link from the operand aligner through the byte lanes to the merger
`timescale 1ns/1ps
`default_nettype none

`include "bitCount_cfg.svh"

interface countPipeIf import countDataPkg::*; ();

	// stage one register outputs
	logic stageValid;
	operandT aligned;

	// per-lane leading-zero counts, index 7 is the most significant byte
	laneCountT laneCount [`BC_NUM_LANES];

	modport align (
		output stageValid,
		output aligned
	);

	modport lane (
		input aligned,
		output laneCount
	);

	modport merge (
		input stageValid,
		input laneCount
	);

endinterface

`default_nettype wire

// File: logic/operandAligner.sv
// stage one: turns any count request into a leading-zero count of a padded word
`timescale 1ns/1ps
`default_nettype none

`include "bitCount_cfg.svh"

module operandAligner import countOpPkg::*, countDataPkg::*; (
	input logic clk,
	input logic rstN,
	input logic ce,
	input operandT operand,
	input countOpT op,
	input opWidthT width,
	countPipeIf.align pipe
);

	logic invert;
	logic trailing;
	logic [5:0] padShift;
	operandT src;
	operandT reversed;
	operandT padMask;
	operandT leadForm;
	operandT nextAligned;

	// ones counts become zero counts once the operand is inverted
	assign invert = (op == opLeadOne) || (op == opTrailOne);
	assign trailing = (op == opTrailZero) || (op == opTrailOne);

	// number of bits below the selected field once it sits at the top
	always_comb begin
		unique case (width)
			width8:  padShift = 6'(`BC_OPERAND_WIDTH - 8);
			width16: padShift = 6'(`BC_OPERAND_WIDTH - 16);
			width32: padShift = 6'(`BC_OPERAND_WIDTH - 32);
			default: padShift = 6'd0;
		endcase
	end

	assign src = invert ? ~operand : operand;

	// full reversal puts bit 0 at the top, so the low W bits land
	// reversed in the top W positions without a per-width mux
	always_comb begin
		for (int i = 0; i < `BC_OPERAND_WIDTH; i++) begin
			reversed[i] = src[`BC_OPERAND_WIDTH-1-i];
		end
	end

	// ones below the field stop the count at W
	assign padMask = ~({`BC_OPERAND_WIDTH{1'b1}} << padShift);

	// leading form shifts the low W bits up to the top
	assign leadForm = src << padShift;

	// garbage from the upper operand bits is covered by the padding either way
	assign nextAligned = (trailing ? reversed : leadForm) | padMask;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pipe.stageValid <= 1'b0;
		end else begin
			pipe.stageValid <= ce;
		end
	end

	// payload only moves on a capture
	always_ff @(posedge clk) begin
		if (ce) begin
			pipe.aligned <= nextAligned;
		end
	end

	// padding of the captured width must reach the lanes intact,
	// otherwise a short field could count into the lower bytes
	padFilled: assert property (
		@(posedge clk) disable iff (!rstN)
		pipe.stageValid |-> ((pipe.aligned & $past(padMask)) == $past(padMask))
	) else $error("aligned word lost its padding ones");

endmodule

`default_nettype wire

// File: logic/byteLeadZero.sv
// byte lane: leading-zero count of one byte by priority lookup
`timescale 1ns/1ps
`default_nettype none

`include "bitCount_cfg.svh"

module byteLeadZero import countDataPkg::*; (
	input laneDataT data,
	output laneCountT count
);

	// highest set bit wins, a zero byte reports a full lane
	always_comb begin
		casez (data)
			8'b1???????: count = 4'd0;
			8'b01??????: count = 4'd1;
			8'b001?????: count = 4'd2;
			8'b0001????: count = 4'd3;
			8'b00001???: count = 4'd4;
			8'b000001??: count = 4'd5;
			8'b0000001?: count = 4'd6;
			8'b00000001: count = 4'd7;
			default:     count = 4'd8;
		endcase
	end

	// the merger treats the top count bit as the full-lane flag,
	// so 8 must mean exactly an all-zero byte and nothing larger may appear
	always_comb begin
		laneRange: assert (
			(count <= `BC_LANE_COUNT_WIDTH'(`BC_LANE_WIDTH)) &&
			((count == `BC_LANE_COUNT_WIDTH'(`BC_LANE_WIDTH)) == (data == '0))
		) else $error("lane count %0d out of range for data %h", count, data);
	end

endmodule

`default_nettype wire

// File: logic/laneMerger.sv
// stage two: combines the lane counts into the final count and registers it
`timescale 1ns/1ps
`default_nettype none

`include "bitCount_cfg.svh"

module laneMerger import countDataPkg::*; (
	input logic clk,
	input logic rstN,
	countPipeIf.merge pipe,
	output logic resultValid,
	output bitCountT count
);

	logic found;
	bitCountT mergedCount;

	// first lane from the top that holds a one decides the count,
	// every lane above it contributes a full byte of zeros
	always_comb begin
		found = 1'b0;
		mergedCount = bitCountT'(`BC_OPERAND_WIDTH);
		for (int i = `BC_NUM_LANES - 1; i >= 0; i--) begin
			// top bit of a lane count marks a full lane
			if (!found && !pipe.laneCount[i][`BC_LANE_COUNT_WIDTH-1]) begin
				mergedCount = bitCountT'((`BC_NUM_LANES - 1 - i) * `BC_LANE_WIDTH) +
					bitCountT'(pipe.laneCount[i]);
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= pipe.stageValid;
		end
	end

	// count is held between results
	always_ff @(posedge clk) begin
		if (pipe.stageValid) begin
			count <= mergedCount;
		end
	end

	// padding from the aligner keeps the total within the operand
	countRange: assert property (
		@(posedge clk) disable iff (!rstN)
		resultValid |-> (count <= bitCountT'(`BC_OPERAND_WIDTH))
	) else $error("merged count %0d exceeds operand width", count);

endmodule

`default_nettype wire

// File: logic/bitCountUnit.sv
// bit-count unit top: aligner, eight byte lanes and merger in a two-clock pipeline
`timescale 1ns/1ps
`default_nettype none

`include "bitCount_cfg.svh"

module bitCountUnit import countOpPkg::*, countDataPkg::*; (
	input logic clk,
	input logic rstN,
	input logic ce,
	input operandT operand,
	input countOpT op,
	input opWidthT width,
	output logic resultValid,
	output bitCountT count
);

	countPipeIf pipe ();

	operandAligner aligner (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.operand(operand),
		.op(op),
		.width(width),
		.pipe(pipe)
	);

	// lane g counts byte g of the aligned word, lane 7 is the top byte
	for (genvar g = 0; g < `BC_NUM_LANES; g++) begin : genLane
		laneDataT laneIn;

		assign laneIn = pipe.aligned[g*`BC_LANE_WIDTH +: `BC_LANE_WIDTH];

		byteLeadZero lane (
			.data(laneIn),
			.count(pipe.laneCount[g])
		);
	end

	laneMerger merger (
		.clk(clk),
		.rstN(rstN),
		.pipe(pipe),
		.resultValid(resultValid),
		.count(count)
	);

endmodule

`default_nettype wire

// File: bench/bitCountUnitTb.sv
// bit-count unit testbench: directed tests checked against a bit-walking count model
`timescale 1ns/1ps
`default_nettype none

`include "bitCount_cfg.svh"

module bitCountUnitTb import countOpPkg::*, countDataPkg::*; ();

	// roughly twice the cycles the tests below take
	localparam int maxCycles = 2000;

	logic clk;
	logic rstN;
	logic ce;
	operandT operand;
	countOpT op;
	opWidthT width;
	logic resultValid;
	bitCountT count;

	integer seed;
	int cycleCount;
	int errorCount;
	int resultCount;

	// one entry per capture, in capture order
	bitCountT expectQ[$];
	int dueQ[$];
	operandT operandQ[$];
	countOpT opQ[$];
	opWidthT widthQ[$];

	bitCountUnit UUT (
		.clk(clk),
		.rstN(rstN),
		.ce(ce),
		.operand(operand),
		.op(op),
		.width(width),
		.resultValid(resultValid),
		.count(count)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= maxCycles) begin
			$display("timeout: run did not finish within %0d cycles", maxCycles);
			$display("test failed");
			$finish;
		end
	end

	// results are sampled half a cycle after the edge that produced them
	always @(negedge clk) begin
		if (resultValid === 1'b1) begin
			if (expectQ.size() == 0) begin
				$display("resultValid pulsed at cycle %0d with no capture pending", cycleCount);
				errorCount++;
			end else begin
				if (dueQ[0] != cycleCount) begin
					$display("result due at cycle %0d arrived at cycle %0d", dueQ[0], cycleCount);
					errorCount++;
				end
				if (count !== expectQ[0]) begin
					$display("Fail count: expected %h, got %h (operand %h, %s, %s)",
						expectQ[0], count, operandQ[0], opQ[0].name(), widthQ[0].name());
					errorCount++;
				end
				resultCount++;
				void'(expectQ.pop_front());
				void'(dueQ.pop_front());
				void'(operandQ.pop_front());
				void'(opQ.pop_front());
				void'(widthQ.pop_front());
			end
		end else if (dueQ.size() > 0 && dueQ[0] <= cycleCount) begin
			$display("no result came for the capture due at cycle %0d", dueQ[0]);
			errorCount++;
			void'(expectQ.pop_front());
			void'(dueQ.pop_front());
			void'(operandQ.pop_front());
			void'(opQ.pop_front());
			void'(widthQ.pop_front());
		end
	end

	function automatic int fieldBits(input opWidthT w);
		case (w)
			width8:  return 8;
			width16: return 16;
			width32: return 32;
			default: return 64;
		endcase
	endfunction

	function automatic operandT randomOperand();
		return {$random(seed), $random(seed)};
	endfunction

	// count matching bits from the counted end of the field until one differs
	task automatic modelCount(input operandT value, input countOpT kind, input opWidthT w,
		output bitCountT result);
		int bits;
		int idx;
		int n;
		logic target;
		logic fromTop;
		logic stopped;
		bits = fieldBits(w);
		target = (kind == opLeadOne) || (kind == opTrailOne);
		fromTop = (kind == opLeadZero) || (kind == opLeadOne);
		n = 0;
		stopped = 1'b0;
		for (int k = 0; k < bits; k++) begin
			idx = fromTop ? bits - 1 - k : k;
			if (!stopped && value[idx] == target) begin
				n++;
			end else begin
				stopped = 1'b1;
			end
		end
		result = bitCountT'(n);
	endtask

	task automatic waitCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// one ce strobe, its result is due in the cycle after the second edge
	task automatic sendOp(input operandT value, input countOpT kind, input opWidthT w);
		bitCountT expected;
		modelCount(value, kind, w, expected);
		operand = value;
		op = kind;
		width = w;
		ce = 1'b1;
		expectQ.push_back(expected);
		dueQ.push_back(cycleCount + 2);
		operandQ.push_back(value);
		opQ.push_back(kind);
		widthQ.push_back(w);
		waitCycles(1);
		ce = 1'b0;
	endtask

	// a few idle cycles at the end catch any extra pulse
	task automatic drainResults();
		while (dueQ.size() > 0) begin
			waitCycles(1);
		end
		waitCycles(3);
	endtask

	task automatic checkResetState();
		rstN = 1'b0;
		repeat (3) begin
			waitCycles(1);
			if (resultValid !== 1'b0) begin
				$display("Fail resultValid: expected 0, got %h during reset", resultValid);
				errorCount++;
			end
		end
		rstN = 1'b1;
		repeat (2) begin
			waitCycles(1);
			if (resultValid !== 1'b0) begin
				$display("Fail resultValid: expected 0, got %h after reset", resultValid);
				errorCount++;
			end
		end
	endtask

	// all zeros, all ones, a walking one and random values at every width
	task automatic runPatterns(input countOpT kind, input logic invert);
		operandT value;
		opWidthT w;
		for (int wi = 0; wi < 4; wi++) begin
			w = opWidthT'(wi);
			sendOp('0, kind, w);
			sendOp('1, kind, w);
			for (int b = 0; b < fieldBits(w); b++) begin
				value = operandT'(1) << b;
				sendOp(invert ? ~value : value, kind, w);
			end
			repeat (4) begin
				sendOp(randomOperand(), kind, w);
			end
		end
		drainResults();
	endtask

	task automatic checkUpperIgnored();
		operandT garbage;
		operandT lowMask;
		opWidthT w;
		logic [31:0] r;
		for (int wi = 0; wi < 3; wi++) begin
			w = opWidthT'(wi);
			lowMask = ~({`BC_OPERAND_WIDTH{1'b1}} << fieldBits(w));
			repeat (6) begin
				garbage = randomOperand();
				r = $random(seed);
				// cleared field counts the full width whatever sits above it
				sendOp(garbage & ~lowMask, opLeadZero, w);
				sendOp(garbage, countOpT'(r[1:0]), w);
			end
		end
		drainResults();
	endtask

	task automatic streamRandom();
		logic [31:0] r;
		for (int i = 0; i < 100; i++) begin
			r = $random(seed);
			sendOp(randomOperand(), countOpT'(r[1:0]), opWidthT'(r[3:2]));
			if (r[4]) begin
				waitCycles(int'(r[6:5]) + 1);
			end
		end
		drainResults();
	endtask

	initial begin
		seed = 32'h1687_2870;
		clk = 1'b0;
		rstN = 1'b0;
		ce = 1'b0;
		operand = '0;
		op = opLeadZero;
		width = width8;
		cycleCount = 0;
		errorCount = 0;
		resultCount = 0;

		checkResetState();
		runPatterns(opLeadZero, 1'b0);
		runPatterns(opLeadOne, 1'b1);
		runPatterns(opTrailZero, 1'b0);
		runPatterns(opTrailOne, 1'b1);
		checkUpperIgnored();
		streamRandom();

		$display("errors: %0d, results checked: %0d, cycles: %0d",
			errorCount, resultCount, cycleCount);
		if (errorCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/countOpPkg.sv
logic/countDataPkg.sv
logic/countPipeIf.sv
logic/operandAligner.sv
logic/byteLeadZero.sv
logic/laneMerger.sv
logic/bitCountUnit.sv
bench/bitCountUnitTb.sv

// File: Makefile
# Verilator build and run of the bit-count unit testbench

TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= bitCountUnitTb
FILELIST ?= compile.f
BUILD    ?= obj_dir
PASSMSG  := test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP), look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	@out="$$(./$(BUILD)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(BUILD)
